// ==== hw/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

`default_nettype none

// image side length, square frames
`define IMG_WIDTH 8
`define OUT_CH    2

// field widths
`define PIX_W     8
`define COEF_W    8
`define BIAS_W    16
`define ACC_W     20

// 3x3 kernel
`define TAPS      9

`default_nettype wire

`endif

// ==== hw/conv_pkg.sv ====
`include "conv_defines.svh"
`default_nettype none

package conv_pkg;

	typedef logic signed [`PIX_W-1:0] pixel_t;
	typedef logic [`BIAS_W-1:0] coef_word_t;
	// low bits of a coefficient word
	typedef logic signed [`COEF_W-1:0] weight_t;
	typedef logic signed [`BIAS_W-1:0] bias_t;
	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic [$clog2(`IMG_WIDTH)-1:0] pos_t;

	// [row][col], row 0 oldest
	typedef pixel_t [0:2][0:2] window_t;

	// [channel][tap], tap k at row k/3, col k%3
	typedef weight_t [`OUT_CH-1:0][`TAPS-1:0] weights_t;
	typedef bias_t [`OUT_CH-1:0] biases_t;

	// channel 0 in the low bits
	typedef acc_t [`OUT_CH-1:0] result_t;

endpackage

`default_nettype wire

// ==== hw/window_if.sv ====
`default_nettype none
`timescale 1ns/1ns

interface window_if;

	logic valid;
	logic ready;
	conv_pkg::window_t win;
	// top-left pixel of the window
	conv_pkg::pos_t row;
	conv_pkg::pos_t col;

	modport src (
		output valid,
		output win,
		output row,
		output col,
		input  ready
	);

	modport dst (
		input  valid,
		input  win,
		input  row,
		input  col,
		output ready
	);

endinterface

`default_nettype wire

// ==== hw/coef_chain.sv ====
`default_nettype none
`timescale 1ns/1ns

module coef_chain #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  T     din,
	output T     entries [DEPTH],
	output logic full
);

	logic [$clog2(DEPTH+1)-1:0] fill_cnt;
	logic shift;

	assign full = (fill_cnt == DEPTH);
	assign shift = load && !full;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			fill_cnt <= '0;
		end
		else if (shift)
		begin
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

	// new word enters at the top, first word ends up in entry 0
	always_ff @(posedge clk)
	begin
		if (shift)
		begin
			entries[DEPTH-1] <= din;
			for (int i = 0; i < DEPTH - 1; i++)
			begin
				entries[i] <= entries[i+1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/coef_regs.sv ====
`include "conv_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module coef_regs (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  coef_valid,
	output logic                  coef_ready,
	input  conv_pkg::coef_word_t  coef_data,
	output conv_pkg::weights_t    weights,
	output conv_pkg::biases_t     biases,
	output logic                  coef_loaded
);

	conv_pkg::weight_t weight_flat [`OUT_CH*`TAPS];
	conv_pkg::bias_t bias_flat [`OUT_CH];
	logic accept;
	logic weights_full;
	logic biases_full;

	// stream closes for good once the last bias is in
	assign coef_ready = !biases_full;
	assign coef_loaded = biases_full;
	assign accept = coef_valid && coef_ready;

	coef_chain #(
		.T(conv_pkg::weight_t),
		.DEPTH(`OUT_CH*`TAPS)
	) weight_chain (
		.clk(clk),
		.rst(rst),
		.load(accept && !weights_full),
		.din(conv_pkg::weight_t'(coef_data[`COEF_W-1:0])),
		.entries(weight_flat),
		.full(weights_full)
	);

	// biases follow the weights
	coef_chain #(
		.T(conv_pkg::bias_t),
		.DEPTH(`OUT_CH)
	) bias_chain (
		.clk(clk),
		.rst(rst),
		.load(accept && weights_full),
		.din(conv_pkg::bias_t'(coef_data)),
		.entries(bias_flat),
		.full(biases_full)
	);

	// channel by channel, taps row-major
	always_comb
	begin
		for (int c = 0; c < `OUT_CH; c++)
		begin
			biases[c] = bias_flat[c];
			for (int t = 0; t < `TAPS; t++)
			begin
				weights[c][t] = weight_flat[c*`TAPS+t];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/line_window.sv ====
`include "conv_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module line_window (
	input  logic              clk,
	input  logic              rst,
	input  logic              enable,
	input  logic              pix_valid,
	output logic              pix_ready,
	input  conv_pkg::pixel_t  pix_data,
	window_if.src             win_out
);

	localparam int LINE_DEPTH = `IMG_WIDTH - 3;
	localparam conv_pkg::pos_t LAST_POS = conv_pkg::pos_t'(`IMG_WIDTH - 1);

	conv_pkg::pixel_t line0 [LINE_DEPTH];
	conv_pkg::pixel_t line1 [LINE_DEPTH];
	conv_pkg::window_t win_q;
	conv_pkg::pos_t col_cnt;
	conv_pkg::pos_t row_cnt;
	logic pix_accept;
	logic win_done;

	// window regs double as the output register, so they hold while it waits
	assign pix_ready = enable && (!win_out.valid || win_out.ready);
	assign pix_accept = pix_valid && pix_ready;
	assign win_done = (row_cnt >= 2) && (col_cnt >= 2);
	assign win_out.win = win_q;

	// column shift regs plus row delay lines
	always_ff @(posedge clk)
	begin
		if (pix_accept)
		begin
			for (int r = 0; r < 3; r++)
			begin
				win_q[r][0] <= win_q[r][1];
				win_q[r][1] <= win_q[r][2];
			end
			win_q[2][2] <= pix_data;
			win_q[1][2] <= line1[LINE_DEPTH-1];
			win_q[0][2] <= line0[LINE_DEPTH-1];
			line1[0] <= win_q[2][0];
			line0[0] <= win_q[1][0];
			for (int i = 1; i < LINE_DEPTH; i++)
			begin
				line1[i] <= line1[i-1];
				line0[i] <= line0[i-1];
			end
		end
	end

	// raster position of the incoming pixel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			col_cnt <= '0;
			row_cnt <= '0;
		end
		else if (pix_accept)
		begin
			if (col_cnt == LAST_POS)
			begin
				col_cnt <= '0;
				if (row_cnt == LAST_POS)
					row_cnt <= '0;
				else
					row_cnt <= row_cnt + 1'b1;
			end
			else
			begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win_out.valid <= 1'b0;
		end
		else if (pix_accept)
		begin
			win_out.valid <= win_done;
		end
		else if (win_out.ready)
		begin
			win_out.valid <= 1'b0;
		end
	end

	// top-left corner of the finished window
	always_ff @(posedge clk)
	begin
		if (pix_accept && win_done)
		begin
			win_out.row <= row_cnt - 2'd2;
			win_out.col <= col_cnt - 2'd2;
		end
	end

endmodule

`default_nettype wire

// ==== hw/conv_mac.sv ====
`include "conv_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module conv_mac (
	input  logic                clk,
	input  logic                rst,
	window_if.dst               win_in,
	input  conv_pkg::weights_t  weights,
	input  conv_pkg::biases_t   biases,
	output logic                out_valid,
	input  logic                out_ready,
	output conv_pkg::result_t   out_data,
	output conv_pkg::pos_t      out_row,
	output conv_pkg::pos_t      out_col,
	output logic                frame_done
);

	localparam conv_pkg::pos_t LAST_POS = conv_pkg::pos_t'(`IMG_WIDTH - 3);

	typedef logic signed [`PIX_W+`COEF_W-1:0] prod_t;

	prod_t prod_q [`OUT_CH][`TAPS];
	conv_pkg::pos_t prod_row;
	conv_pkg::pos_t prod_col;
	logic prod_valid;
	logic prod_take;
	logic out_take;
	conv_pkg::result_t sum_d;

	// nine products plus bias, balanced tree
	function automatic conv_pkg::acc_t adder_tree(input prod_t p [`TAPS],
		input conv_pkg::bias_t b);
		conv_pkg::acc_t s0;
		conv_pkg::acc_t s1;
		conv_pkg::acc_t s2;
		conv_pkg::acc_t s3;
		conv_pkg::acc_t t0;
		conv_pkg::acc_t t1;
		conv_pkg::acc_t tail;
		s0 = p[0] + p[1];
		s1 = p[2] + p[3];
		s2 = p[4] + p[5];
		s3 = p[6] + p[7];
		tail = p[8] + b;
		t0 = s0 + s1;
		t1 = s2 + s3;
		return t0 + t1 + tail;
	endfunction

	// a stage moves when empty or when the next one takes its item
	assign out_take = !out_valid || out_ready;
	assign prod_take = !prod_valid || out_take;
	assign win_in.ready = prod_take;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prod_valid <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			if (prod_take)
				prod_valid <= win_in.valid;
			if (out_take)
				out_valid <= prod_valid;
		end
	end

	// product stage
	always_ff @(posedge clk)
	begin
		if (prod_take && win_in.valid)
		begin
			for (int c = 0; c < `OUT_CH; c++)
			begin
				for (int t = 0; t < `TAPS; t++)
				begin
					prod_q[c][t] <= $signed(win_in.win[t/3][t%3]) * $signed(weights[c][t]);
				end
			end
			prod_row <= win_in.row;
			prod_col <= win_in.col;
		end
	end

	always_comb
	begin
		for (int c = 0; c < `OUT_CH; c++)
		begin
			sum_d[c] = adder_tree(prod_q[c], biases[c]);
		end
	end

	// sum stage, also the output register
	always_ff @(posedge clk)
	begin
		if (out_take && prod_valid)
		begin
			out_data <= sum_d;
			out_row <= prod_row;
			out_col <= prod_col;
		end
	end

	// last window of the frame leaving
	assign frame_done = out_valid && out_ready && (out_row == LAST_POS) && (out_col == LAST_POS);

endmodule

`default_nettype wire

// ==== hw/conv_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module conv_top (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  coef_valid,
	output logic                  coef_ready,
	input  conv_pkg::coef_word_t  coef_data,

	input  logic                  pix_valid,
	output logic                  pix_ready,
	input  conv_pkg::pixel_t      pix_data,

	output logic                  out_valid,
	input  logic                  out_ready,
	output conv_pkg::result_t     out_data,
	output conv_pkg::pos_t        out_row,
	output conv_pkg::pos_t        out_col,
	output logic                  frame_done
);

	conv_pkg::weights_t weights;
	conv_pkg::biases_t biases;
	logic coef_loaded;

	window_if win_bus ();

	coef_regs u_coef_regs (
		.clk(clk),
		.rst(rst),
		.coef_valid(coef_valid),
		.coef_ready(coef_ready),
		.coef_data(coef_data),
		.weights(weights),
		.biases(biases),
		.coef_loaded(coef_loaded)
	);

	// pixels held off until all coefficients are in
	line_window u_line_window (
		.clk(clk),
		.rst(rst),
		.enable(coef_loaded),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.pix_data(pix_data),
		.win_out(win_bus.src)
	);

	conv_mac u_conv_mac (
		.clk(clk),
		.rst(rst),
		.win_in(win_bus.dst),
		.weights(weights),
		.biases(biases),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_row(out_row),
		.out_col(out_col),
		.frame_done(frame_done)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_clkgen (
	input  logic reset_req,
	output logic clk,
	output logic rst
);

	int hold;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		hold = 16;
	end

	// reset spans 16 rising edges, at start and after each request
	always @(posedge clk)
	begin
		if (reset_req)
		begin
			rst <= 1'b1;
			hold <= 16;
		end
		else if (hold > 1)
		begin
			hold <= hold - 1;
		end
		else
		begin
			rst <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== tb/conv_chk.sv ====
`include "conv_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module conv_chk (
	input logic                clk,
	input logic                rst,
	input logic                coef_valid,
	input logic                coef_ready,
	input logic                coef_loaded,
	input logic                pix_ready,
	input logic                out_valid,
	input logic                out_ready,
	input conv_pkg::result_t   out_data,
	input conv_pkg::pos_t      out_row,
	input conv_pkg::pos_t      out_col,
	input logic                frame_done
);

	localparam int COEF_WORDS = `OUT_CH * `TAPS + `OUT_CH;
	localparam int NOUT = (`IMG_WIDTH - 2) * (`IMG_WIDTH - 2);

	int coef_cnt;
	int out_cnt;

	// words taken from the coefficient stream since reset
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			coef_cnt <= 0;
		else if (coef_valid && coef_ready)
			coef_cnt <= coef_cnt + 1;
	end

	// results accepted so far in the current frame
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			out_cnt <= 0;
		else if (out_valid && out_ready)
			out_cnt <= (out_cnt == NOUT - 1) ? 0 : out_cnt + 1;
	end

	// a stalled result keeps its value and position
	property stall_holds;
		@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=>
			out_valid && $stable(out_data) && $stable(out_row) && $stable(out_col);
	endproperty

	property no_pixels_early;
		@(posedge clk) disable iff (rst)
		coef_cnt < COEF_WORDS |-> !coef_loaded && !pix_ready;
	endproperty

	property coef_closed;
		@(posedge clk) disable iff (rst)
		coef_cnt >= COEF_WORDS |-> coef_loaded && !coef_ready;
	endproperty

	property done_on_handshake;
		@(posedge clk) disable iff (rst)
		frame_done == (out_valid && out_ready && out_cnt == NOUT - 1);
	endproperty

	a_stall_holds: assert property (stall_holds)
		else $error("result or out_valid changed while out_ready was low");
	a_no_pixels_early: assert property (no_pixels_early)
		else $error("pix_ready or coef_loaded high before all coefficients were taken");
	a_coef_closed: assert property (coef_closed)
		else $error("coef_ready high or coef_loaded low after all coefficients were taken");
	a_done_on_handshake: assert property (done_on_handshake)
		else $error("frame_done not matching the last output handshake of a frame");

endmodule

`default_nettype wire

// ==== tb/conv_tb.sv ====
`include "conv_defines.svh"
`default_nettype none
`timescale 1ns/1ns

module conv_tb;

	localparam int NPIX = `IMG_WIDTH * `IMG_WIDTH;
	localparam int OUT_SIDE = `IMG_WIDTH - 2;
	localparam int NOUT = OUT_SIDE * OUT_SIDE;
	localparam int COEF_WORDS = `OUT_CH * `TAPS + `OUT_CH;
	localparam int NUM_TESTS = 5;
	// rows of the table that reload coefficients
	localparam int NUM_LOADS = 3;
	localparam int TIMEOUT_CYCLES = 4 * (COEF_WORDS * NUM_LOADS + NUM_TESTS * NPIX) + 200;

	localparam int W_CENTRE = 0;
	localparam int W_RAND = 1;
	localparam int W_MIN = 2;
	localparam int P_RAMP = 0;
	localparam int P_RAND = 1;
	localparam int P_MIN = 2;

	typedef struct {
		bit reload;
		int wkind;
		conv_pkg::bias_t bias0;
		conv_pkg::bias_t bias1;
		int pkind;
		int duty;
	} test_row_t;

	// rows without reload keep the coefficients of the row before
	test_row_t tests [NUM_TESTS] = '{
		'{1'b1, W_CENTRE, 16'sd100, -16'sd50, P_RAMP, 100},
		'{1'b1, W_RAND, 16'sd1234, -16'sd4321, P_RAND, 100},
		'{1'b0, W_RAND, 16'sd0, 16'sd0, P_RAND, 50},
		'{1'b0, W_RAND, 16'sd0, 16'sd0, P_RAND, 100},
		'{1'b1, W_MIN, 16'sd32767, 16'sh8000, P_MIN, 50}
	};

	logic clk;
	logic rst;
	logic reset_req;
	logic coef_valid;
	logic coef_ready;
	conv_pkg::coef_word_t coef_data;
	logic pix_valid;
	logic pix_ready;
	conv_pkg::pixel_t pix_data;
	logic out_valid;
	logic out_ready;
	conv_pkg::result_t out_data;
	conv_pkg::pos_t out_row;
	conv_pkg::pos_t out_col;
	logic frame_done;

	conv_pkg::weights_t w_model;
	conv_pkg::biases_t b_model;
	conv_pkg::pixel_t frame_pix [NPIX];
	integer seed = 57;
	int cycle_cnt = 0;
	int check_cnt = 0;
	int err_cnt = 0;
	int test_errs = 0;

	tb_clkgen u_clkgen (
		.reset_req(reset_req),
		.clk(clk),
		.rst(rst)
	);

	conv_top DUT (
		.clk(clk),
		.rst(rst),
		.coef_valid(coef_valid),
		.coef_ready(coef_ready),
		.coef_data(coef_data),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.pix_data(pix_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_row(out_row),
		.out_col(out_col),
		.frame_done(frame_done)
	);

	bind conv_top conv_chk u_chk (
		.clk(clk),
		.rst(rst),
		.coef_valid(coef_valid),
		.coef_ready(coef_ready),
		.coef_loaded(coef_loaded),
		.pix_ready(pix_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_row(out_row),
		.out_col(out_col),
		.frame_done(frame_done)
	);

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check_result(input conv_pkg::result_t got, input conv_pkg::result_t exp,
		input string what);
		check_cnt++;
		if (got !== exp)
		begin
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
			test_errs++;
		end
	endtask

	task automatic check_pos(input conv_pkg::pos_t got, input conv_pkg::pos_t exp,
		input string what);
		check_cnt++;
		if (got !== exp)
		begin
			$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
			err_cnt++;
			test_errs++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		check_cnt++;
		if (got !== exp)
		begin
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
			err_cnt++;
			test_errs++;
		end
	endtask

	// nine taps, row-major, full-width signed sum plus bias
	function automatic conv_pkg::result_t model_result(input int r, input int c);
		conv_pkg::result_t res;
		int sum;
		for (int ch = 0; ch < `OUT_CH; ch++)
		begin
			sum = int'($signed(b_model[ch]));
			for (int k = 0; k < `TAPS; k++)
			begin
				sum += int'(frame_pix[(r + k / 3) * `IMG_WIDTH + c + k % 3])
					* int'($signed(w_model[ch][k]));
			end
			res[ch] = conv_pkg::acc_t'(sum);
		end
		return res;
	endfunction

	function automatic logic ready_draw(input int duty);
		return ($unsigned($random(seed)) % 100) < duty;
	endfunction

	task automatic apply_reset();
		coef_valid <= 1'b0;
		pix_valid <= 1'b0;
		out_ready <= 1'b0;
		reset_req <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		@(posedge clk);
		while (rst)
			@(posedge clk);
		check_bit(coef_ready, 1'b1, "coef_ready after reset");
		check_bit(pix_ready, 1'b0, "pix_ready after reset");
		check_bit(out_valid, 1'b0, "out_valid after reset");
	endtask

	task automatic set_coefs(input test_row_t row);
		for (int c = 0; c < `OUT_CH; c++)
		begin
			for (int t = 0; t < `TAPS; t++)
			begin
				case (row.wkind)
					W_CENTRE: w_model[c][t] = conv_pkg::weight_t'((t == 4) ? 1 : 0);
					W_MIN: w_model[c][t] = conv_pkg::weight_t'(-128);
					default: w_model[c][t] = conv_pkg::weight_t'($random(seed));
				endcase
			end
			b_model[c] = (c % 2 == 0) ? row.bias0 : row.bias1;
		end
	endtask

	task automatic load_coefs();
		conv_pkg::coef_word_t words [COEF_WORDS];
		int n;
		// junk in the upper bits of weight words
		for (int c = 0; c < `OUT_CH; c++)
		begin
			for (int t = 0; t < `TAPS; t++)
			begin
				words[c*`TAPS+t] = conv_pkg::coef_word_t'($random(seed));
				words[c*`TAPS+t][`COEF_W-1:0] = w_model[c][t];
			end
			words[`OUT_CH*`TAPS+c] = b_model[c];
		end
		n = 0;
		coef_valid <= 1'b1;
		coef_data <= words[0];
		while (n < COEF_WORDS)
		begin
			@(posedge clk);
			check_bit(coef_ready, 1'b1, "coef_ready during load");
			if (coef_ready)
			begin
				n++;
				if (n < COEF_WORDS)
					coef_data <= words[n];
			end
		end
		// one word too many, must be refused
		coef_data <= 16'hdead;
		repeat (3)
		begin
			@(posedge clk);
			check_bit(coef_ready, 1'b0, "coef_ready after last bias");
		end
		coef_valid <= 1'b0;
	endtask

	task automatic make_frame(input int kind);
		for (int i = 0; i < NPIX; i++)
		begin
			case (kind)
				P_RAMP: frame_pix[i] = conv_pkg::pixel_t'(i * 3 - 90);
				P_MIN: frame_pix[i] = conv_pkg::pixel_t'(-128);
				default: frame_pix[i] = conv_pkg::pixel_t'($random(seed));
			endcase
		end
	endtask

	task automatic send_frame();
		int n;
		n = 0;
		pix_valid <= 1'b1;
		pix_data <= frame_pix[0];
		while (n < NPIX)
		begin
			@(posedge clk);
			if (pix_ready)
			begin
				n++;
				if (n < NPIX)
					pix_data <= frame_pix[n];
				else
					pix_valid <= 1'b0;
			end
		end
	endtask

	task automatic collect_frame(input int duty);
		int n;
		int done_cnt;
		n = 0;
		done_cnt = 0;
		out_ready <= ready_draw(duty);
		while (n < NOUT)
		begin
			@(posedge clk);
			if (frame_done)
				done_cnt++;
			if (out_valid && out_ready)
			begin
				check_result(out_data, model_result(n / OUT_SIDE, n % OUT_SIDE), "out_data");
				check_pos(out_row, conv_pkg::pos_t'(n / OUT_SIDE), "out_row");
				check_pos(out_col, conv_pkg::pos_t'(n % OUT_SIDE), "out_col");
				check_bit(frame_done, n == NOUT - 1, "frame_done");
				n++;
			end
			out_ready <= ready_draw(duty);
		end
		out_ready <= 1'b0;
		if (done_cnt != 1)
		begin
			$display("frame_done was seen %0d times in one frame instead of once", done_cnt);
			err_cnt++;
			test_errs++;
		end
	endtask

	initial
	begin
		reset_req = 1'b0;
		coef_valid = 1'b0;
		coef_data = '0;
		pix_valid = 1'b0;
		pix_data = '0;
		out_ready = 1'b0;
		@(posedge clk);
		for (int i = 0; i < NUM_TESTS; i++)
		begin
			test_errs = 0;
			if (tests[i].reload)
			begin
				apply_reset();
				set_coefs(tests[i]);
				load_coefs();
			end
			make_frame(tests[i].pkind);
			fork
				send_frame();
				collect_frame(tests[i].duty);
			join
			$display("test %0d: %0d results, %0d errors", i, NOUT, test_errs);
		end
		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/conv_pkg.sv
hw/window_if.sv
hw/coef_chain.sv
hw/coef_regs.sv
hw/line_window.sv
hw/conv_mac.sv
hw/conv_top.sv
tb/tb_clkgen.sv
tb/conv_chk.sv
tb/conv_tb.sv
